// ==== Makefile ====
# Verilator build and run of the load/store unit testbench.
# Override any variable on the command line, e.g. make run TOP=tb_lsu

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= lsu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Simulation PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== lsu.f ====
+incdir+source
source/lsu_pkg.sv
source/lsu_agu.sv
source/lsu_bypass.sv
source/lsu_mem_fsm.sv
source/lsu_load_align.sv
source/lsu_top.sv
test/lsu_checker.sv
test/tb_lsu.sv

// ==== source/lsu_agu.sv ====
/*
 * Address generation for a new request. Forms the byte address, the
 * byte enable for the access size, the lane-replicated store data and
 * the misalignment flag. Purely combinational, sits before the buffer.
 */
`timescale 1ns/100ps

module lsu_agu (
    input  lsu_pkg::lsu_op_e op_i,
    input  lsu_pkg::xlen_t   operand_a_i,
    input  lsu_pkg::xlen_t   imm_i,
    input  lsu_pkg::xlen_t   operand_b_i,
    output lsu_pkg::xlen_t   addr_o,
    output lsu_pkg::be_t     be_o,
    output lsu_pkg::xlen_t   wdata_o,
    output logic             misaligned_o
);

    // immediate arrives already sign-extended to full width
    assign addr_o = lsu_pkg::xlen_t'($signed(operand_a_i) + $signed(imm_i));

    // ------------------------------------------------------------------------
    // byte enable and store data by access size
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: begin
                be_o    = lsu_pkg::be_t'(4'b0001 << addr_o[1:0]);
                wdata_o = {4{operand_b_i[7:0]}};
            end
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: begin
                // upper or lower halfword, bit 0 ignored here
                be_o    = addr_o[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{operand_b_i[15:0]}};
            end
            default: begin
                be_o    = 4'b1111;
                wdata_o = operand_b_i;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // misalignment
    // ------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: misaligned_o = addr_o[0];
            lsu_pkg::LW, lsu_pkg::SW:               misaligned_o = |addr_o[1:0];
            // bytes are always aligned
            default:                                misaligned_o = 1'b0;
        endcase
    end

endmodule

// ==== source/lsu_bypass.sv ====
/*
 * Two-entry request buffer between the AGU and the memory FSM.
 * An empty buffer shows the incoming request on the head outputs in the
 * same cycle. Requests wait here while the memory access is busy; the
 * issue side is ready only while the buffer is empty.
 */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_bypass (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             push_i,
    input  lsu_pkg::lsu_op_e push_op_i,
    input  lsu_pkg::xlen_t   push_addr_i,
    input  lsu_pkg::be_t     push_be_i,
    input  lsu_pkg::xlen_t   push_wdata_i,
    input  lsu_pkg::tid_t    push_tid_i,
    input  logic             push_misaligned_i,
    input  logic             pop_i,
    output logic             head_valid_o,
    output lsu_pkg::lsu_op_e head_op_o,
    output lsu_pkg::xlen_t   head_addr_o,
    output lsu_pkg::be_t     head_be_o,
    output lsu_pkg::xlen_t   head_wdata_o,
    output lsu_pkg::tid_t    head_tid_o,
    output logic             head_misaligned_o,
    output logic             ready_o
);

    // entry storage
    lsu_pkg::lsu_op_e op_q         [`LSU_BUF_DEPTH];
    lsu_pkg::xlen_t   addr_q       [`LSU_BUF_DEPTH];
    lsu_pkg::be_t     be_q         [`LSU_BUF_DEPTH];
    lsu_pkg::xlen_t   wdata_q      [`LSU_BUF_DEPTH];
    lsu_pkg::tid_t    tid_q        [`LSU_BUF_DEPTH];
    logic             misaligned_q [`LSU_BUF_DEPTH];

    // one pointer bit covers two entries
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       empty;
    logic       full;

    assign empty   = (count_q == 2'd0);
    assign full    = (count_q == 2'(`LSU_BUF_DEPTH));
    assign ready_o = empty;

    // ------------------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + 2'(push_i) - 2'(pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            op_q[wr_ptr_q]         <= push_op_i;
            addr_q[wr_ptr_q]       <= push_addr_i;
            be_q[wr_ptr_q]         <= push_be_i;
            wdata_q[wr_ptr_q]      <= push_wdata_i;
            tid_q[wr_ptr_q]        <= push_tid_i;
            misaligned_q[wr_ptr_q] <= push_misaligned_i;
        end
    end

    // ------------------------------------------------------------------------
    // head, pass-through when empty
    // ------------------------------------------------------------------------
    assign head_valid_o      = empty ? push_i            : 1'b1;
    assign head_op_o         = empty ? push_op_i         : op_q[rd_ptr_q];
    assign head_addr_o       = empty ? push_addr_i       : addr_q[rd_ptr_q];
    assign head_be_o         = empty ? push_be_i         : be_q[rd_ptr_q];
    assign head_wdata_o      = empty ? push_wdata_i      : wdata_q[rd_ptr_q];
    assign head_tid_o        = empty ? push_tid_i        : tid_q[rd_ptr_q];
    assign head_misaligned_o = empty ? push_misaligned_i : misaligned_q[rd_ptr_q];

    // issuer must respect ready_o
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_i && full));
    // FSM pops only an entry it has been working on
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_i && empty));

endmodule

// ==== source/lsu_defs.svh ====
/*
 * Width, depth and exception-code macros for the load/store unit.
 * Included by the package and by any RTL or testbench file that needs
 * a raw width or an exception code. Definitions only.
 */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ------------------------------------------------------------------------
// data path widths
// ------------------------------------------------------------------------
`define LSU_XLEN        32
`define LSU_TID_BITS    3
`define LSU_BE_BITS     4
// word address, byte offset bits stripped
`define LSU_WADDR_BITS  30

// request buffer entries
`define LSU_BUF_DEPTH   2

// ------------------------------------------------------------------------
// exception codes, RISC-V cause numbers
// ------------------------------------------------------------------------
`define LSU_EXC_BITS           4
`define LSU_EXC_NONE           4'd0
`define LSU_EXC_LD_MISALIGNED  4'd4
`define LSU_EXC_ST_MISALIGNED  4'd6

`endif

// ==== source/lsu_load_align.sv ====
/*
 * Load data alignment. Picks the addressed byte or halfword lane out of
 * the memory word and extends it to full width by operation. Sits
 * combinationally between the memory read data and the FSM capture.
 */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_load_align (
    input  lsu_pkg::xlen_t   rdata_i,
    input  lsu_pkg::lsu_op_e op_i,
    input  logic [1:0]       offset_i,
    output lsu_pkg::xlen_t   data_o
);

    logic [7:0]     byte_lane;
    logic [15:0]    half_lane;
    lsu_pkg::xlen_t shifted;

    // lane select
    assign shifted   = rdata_i >> {offset_i, 3'b000};
    assign byte_lane = shifted[7:0];
    assign half_lane = offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (op_i)
            lsu_pkg::LB:  data_o = {{(`LSU_XLEN-8){byte_lane[7]}}, byte_lane};
            lsu_pkg::LBU: data_o = {{(`LSU_XLEN-8){1'b0}}, byte_lane};
            lsu_pkg::LH:  data_o = {{(`LSU_XLEN-16){half_lane[15]}}, half_lane};
            lsu_pkg::LHU: data_o = {{(`LSU_XLEN-16){1'b0}}, half_lane};
            // LW, stores are not captured
            default:      data_o = rdata_i;
        endcase
    end

endmodule

// ==== source/lsu_mem_fsm.sv ====
/*
 * Memory access FSM. Takes the buffer head, runs the four-phase req/ack
 * handshake with the data memory and issues one write-back pulse per
 * request, popping the buffer in the same cycle. Misaligned requests
 * skip the memory and only report their exception code.
 */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_mem_fsm (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             head_valid_i,
    input  lsu_pkg::lsu_op_e head_op_i,
    input  lsu_pkg::xlen_t   head_addr_i,
    input  lsu_pkg::be_t     head_be_i,
    input  lsu_pkg::xlen_t   head_wdata_i,
    input  lsu_pkg::tid_t    head_tid_i,
    input  logic             head_misaligned_i,
    input  logic             mem_ack_i,
    input  lsu_pkg::xlen_t   load_data_i,
    output logic             pop_o,
    output logic             mem_req_o,
    output logic             mem_we_o,
    output lsu_pkg::waddr_t  mem_addr_o,
    output lsu_pkg::be_t     mem_be_o,
    output lsu_pkg::xlen_t   mem_wdata_o,
    output logic             result_valid_o,
    output lsu_pkg::tid_t    result_trans_id_o,
    output lsu_pkg::xlen_t   result_data_o,
    output lsu_pkg::exc_t    result_exc_o
);

    lsu_pkg::mem_state_e state_q;
    lsu_pkg::mem_state_e state_d;

    logic           is_store;
    lsu_pkg::exc_t  exc_sel;
    lsu_pkg::xlen_t data_q;
    lsu_pkg::exc_t  exc_q;

    assign is_store = head_op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

    always_comb begin
        if (!head_misaligned_i) begin
            exc_sel = `LSU_EXC_NONE;
        end else if (is_store) begin
            exc_sel = `LSU_EXC_ST_MISALIGNED;
        end else begin
            exc_sel = `LSU_EXC_LD_MISALIGNED;
        end
    end

    // ------------------------------------------------------------------------
    // state sequence
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::IDLE: begin
                // misaligned goes through RELEASE with req low, ack is idle
                if (head_valid_i) begin
                    state_d = head_misaligned_i ? lsu_pkg::RELEASE : lsu_pkg::REQ;
                end
            end
            lsu_pkg::REQ: begin
                if (mem_ack_i) begin
                    state_d = lsu_pkg::RELEASE;
                end
            end
            lsu_pkg::RELEASE: begin
                if (!mem_ack_i) begin
                    state_d = lsu_pkg::DONE;
                end
            end
            default: state_d = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= lsu_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // result payload, stores and exceptions return zero
    always_ff @(posedge clk_i) begin
        if (state_q == lsu_pkg::IDLE && head_valid_i) begin
            data_q <= '0;
            exc_q  <= exc_sel;
        end else if (state_q == lsu_pkg::REQ && mem_ack_i && !is_store) begin
            data_q <= load_data_i;
        end
    end

    // ------------------------------------------------------------------------
    // memory port, head stays put in the buffer until the pop
    // ------------------------------------------------------------------------
    assign mem_req_o   = (state_q == lsu_pkg::REQ);
    assign mem_we_o    = is_store;
    assign mem_addr_o  = head_addr_i[`LSU_XLEN-1:2];
    assign mem_be_o    = head_be_i;
    assign mem_wdata_o = head_wdata_i;

    // write-back
    assign result_valid_o    = (state_q == lsu_pkg::DONE);
    assign pop_o             = result_valid_o;
    assign result_trans_id_o = head_tid_i;
    assign result_data_o     = data_q;
    assign result_exc_o      = exc_q;

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o) && $stable(mem_wdata_o));
    // exception path never touches memory
    a_misaligned_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        head_valid_i && head_misaligned_i |-> !mem_req_o);

endmodule

// ==== source/lsu_pkg.sv ====
/*
 * Shared types of the load/store unit: plain vector typedefs for the
 * widths that carry a meaning, the operation encoding and the states of
 * the memory handshake FSM. Referenced by scoped name only.
 */
`include "lsu_defs.svh"

package lsu_pkg;

    // --------------------------------------------------------------------
    // vector types
    // --------------------------------------------------------------------
    // data or byte address word
    typedef logic [`LSU_XLEN-1:0]       xlen_t;
    // scoreboard transaction id
    typedef logic [`LSU_TID_BITS-1:0]   tid_t;
    typedef logic [`LSU_BE_BITS-1:0]    be_t;
    // word address on the memory port
    typedef logic [`LSU_WADDR_BITS-1:0] waddr_t;
    typedef logic [`LSU_EXC_BITS-1:0]   exc_t;

    // --------------------------------------------------------------------
    // operation, fills all eight 3-bit codes
    // --------------------------------------------------------------------
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } lsu_op_e;

    // --------------------------------------------------------------------
    // memory FSM states
    // --------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        DONE
    } mem_state_e;

endpackage

// ==== source/lsu_top.sv ====
/*
 * Load/store unit top level. Issue side enters the AGU, requests wait
 * in the bypass buffer, the memory FSM runs the four-phase handshake and
 * load data is aligned on the way back. Only instances and wires.
 */
`timescale 1ns/100ps

module lsu_top (
    input  logic             clk_i,
    input  logic             rst_ni,
    // issue side
    input  logic             valid_i,
    input  lsu_pkg::lsu_op_e op_i,
    input  lsu_pkg::xlen_t   operand_a_i,
    input  lsu_pkg::xlen_t   operand_b_i,
    input  lsu_pkg::xlen_t   imm_i,
    input  lsu_pkg::tid_t    trans_id_i,
    output logic             ready_o,
    // write-back
    output logic             result_valid_o,
    output lsu_pkg::tid_t    result_trans_id_o,
    output lsu_pkg::xlen_t   result_data_o,
    output lsu_pkg::exc_t    result_exc_o,
    // data memory
    output logic             mem_req_o,
    output logic             mem_we_o,
    output lsu_pkg::waddr_t  mem_addr_o,
    output lsu_pkg::be_t     mem_be_o,
    output lsu_pkg::xlen_t   mem_wdata_o,
    input  logic             mem_ack_i,
    input  lsu_pkg::xlen_t   mem_rdata_i
);

    // ------------------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------------------
    lsu_pkg::xlen_t   agu_addr;
    lsu_pkg::be_t     agu_be;
    lsu_pkg::xlen_t   agu_wdata;
    logic             agu_misaligned;

    logic             head_valid;
    lsu_pkg::lsu_op_e head_op;
    lsu_pkg::xlen_t   head_addr;
    lsu_pkg::be_t     head_be;
    lsu_pkg::xlen_t   head_wdata;
    lsu_pkg::tid_t    head_tid;
    logic             head_misaligned;
    logic             pop;
    lsu_pkg::xlen_t   load_data;

    lsu_agu i_agu (
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .imm_i        (imm_i),
        .operand_b_i  (operand_b_i),
        .addr_o       (agu_addr),
        .be_o         (agu_be),
        .wdata_o      (agu_wdata),
        .misaligned_o (agu_misaligned)
    );

    lsu_bypass i_bypass (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .push_i            (valid_i),
        .push_op_i         (op_i),
        .push_addr_i       (agu_addr),
        .push_be_i         (agu_be),
        .push_wdata_i      (agu_wdata),
        .push_tid_i        (trans_id_i),
        .push_misaligned_i (agu_misaligned),
        .pop_i             (pop),
        .head_valid_o      (head_valid),
        .head_op_o         (head_op),
        .head_addr_o       (head_addr),
        .head_be_o         (head_be),
        .head_wdata_o      (head_wdata),
        .head_tid_o        (head_tid),
        .head_misaligned_o (head_misaligned),
        .ready_o           (ready_o)
    );

    lsu_mem_fsm i_mem_fsm (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .head_valid_i      (head_valid),
        .head_op_i         (head_op),
        .head_addr_i       (head_addr),
        .head_be_i         (head_be),
        .head_wdata_i      (head_wdata),
        .head_tid_i        (head_tid),
        .head_misaligned_i (head_misaligned),
        .mem_ack_i         (mem_ack_i),
        .load_data_i       (load_data),
        .pop_o             (pop),
        .mem_req_o         (mem_req_o),
        .mem_we_o          (mem_we_o),
        .mem_addr_o        (mem_addr_o),
        .mem_be_o          (mem_be_o),
        .mem_wdata_o       (mem_wdata_o),
        .result_valid_o    (result_valid_o),
        .result_trans_id_o (result_trans_id_o),
        .result_data_o     (result_data_o),
        .result_exc_o      (result_exc_o)
    );

    lsu_load_align i_load_align (
        .rdata_i  (mem_rdata_i),
        .op_i     (head_op),
        .offset_i (head_addr[1:0]),
        .data_o   (load_data)
    );

endmodule

// ==== test/lsu_checker.sv ====
/*
 * Result checker for the load/store unit testbench. Keeps a shadow copy
 * of the data memory, predicts every accepted request with a reference
 * model and compares the write-back port in issue order.
 */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_checker (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             valid_i,
    input  logic             ready_i,
    input  lsu_pkg::lsu_op_e op_i,
    input  lsu_pkg::xlen_t   operand_a_i,
    input  lsu_pkg::xlen_t   operand_b_i,
    input  lsu_pkg::xlen_t   imm_i,
    input  lsu_pkg::tid_t    trans_id_i,
    input  logic             mem_req_i,
    input  logic             result_valid_i,
    input  lsu_pkg::tid_t    result_trans_id_i,
    input  lsu_pkg::xlen_t   result_data_i,
    input  lsu_pkg::exc_t    result_exc_i,
    output int               accepted_o,
    output int               pending_o,
    output int               mismatch_o,
    output int               extra_o
);

    localparam int MEM_WORDS = 64;

    lsu_pkg::xlen_t shadow [MEM_WORDS];
    lsu_pkg::tid_t  tid_q  [$];
    lsu_pkg::xlen_t data_q [$];
    lsu_pkg::exc_t  exc_q  [$];
    logic           after_reset;

    // same pattern as the responder memory, each byte from its own address
    function automatic lsu_pkg::xlen_t fill_word(input int idx);
        logic [7:0] b;
        b = 8'(idx * 4);
        return {4{b}} ^ 32'hc35a_96e1;
    endfunction

    // ------------------------------------------------------------------------
    // reference model, updates the shadow memory on stores
    // ------------------------------------------------------------------------
    function automatic lsu_pkg::xlen_t expect_result(
        input  lsu_pkg::lsu_op_e op,
        input  lsu_pkg::xlen_t   a,
        input  lsu_pkg::xlen_t   b,
        input  lsu_pkg::xlen_t   imm,
        output lsu_pkg::exc_t    exc
    );
        lsu_pkg::xlen_t addr;
        lsu_pkg::xlen_t word;
        logic [1:0]     off;
        logic [7:0]     lane8;
        logic [15:0]    lane16;
        logic           is_store;
        logic           bad;

        addr     = a + imm;
        off      = addr[1:0];
        word     = shadow[addr[7:2]];
        is_store = op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
        bad      = ((op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) && off[0])
                || ((op inside {lsu_pkg::LW, lsu_pkg::SW}) && off != 2'b00);
        exc = `LSU_EXC_NONE;
        if (bad) begin
            exc = is_store ? `LSU_EXC_ST_MISALIGNED : `LSU_EXC_LD_MISALIGNED;
            return '0;
        end
        lane8  = word[8*off +: 8];
        lane16 = off[1] ? word[31:16] : word[15:0];
        case (op)
            lsu_pkg::LB:  return {{24{lane8[7]}}, lane8};
            lsu_pkg::LBU: return {24'd0, lane8};
            lsu_pkg::LH:  return {{16{lane16[15]}}, lane16};
            lsu_pkg::LHU: return {16'd0, lane16};
            lsu_pkg::LW:  return word;
            lsu_pkg::SB:  word[8*off +: 8] = b[7:0];
            lsu_pkg::SH:  word[16*off[1] +: 16] = b[15:0];
            default:      word = b;
        endcase
        shadow[addr[7:2]] = word;
        return '0;
    endfunction

    // ------------------------------------------------------------------------
    // compare in issue order
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin : compare
        lsu_pkg::tid_t  exp_tid;
        lsu_pkg::xlen_t exp_data;
        lsu_pkg::exc_t  exp_exc;

        if (!rst_ni) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                shadow[i] = fill_word(i);
            end
            tid_q.delete();
            data_q.delete();
            exc_q.delete();
            accepted_o  = 0;
            mismatch_o  = 0;
            extra_o     = 0;
            after_reset = 1'b1;
        end else begin
            if (after_reset && (!ready_i || mem_req_i || result_valid_i)) begin
                mismatch_o++;
                $display("FAIL at %0t ns: after reset ready %b mem_req %b result_valid %b",
                         $time, ready_i, mem_req_i, result_valid_i);
            end
            after_reset = 1'b0;
            // a held request must keep the issue side closed
            if (ready_i && tid_q.size() != 0) begin
                mismatch_o++;
                $display("FAIL at %0t ns: ready high while a request is held", $time);
            end
            if (result_valid_i) begin
                if (tid_q.size() == 0) begin
                    extra_o++;
                    $display("extra result at %0t ns: trans id %0d with nothing outstanding",
                             $time, result_trans_id_i);
                end else begin
                    exp_tid  = tid_q.pop_front();
                    exp_data = data_q.pop_front();
                    exp_exc  = exc_q.pop_front();
                    if (result_trans_id_i !== exp_tid || result_data_i !== exp_data
                            || result_exc_i !== exp_exc) begin
                        mismatch_o++;
                        $display("FAIL at %0t ns: tid %0d data %h exc %0d, expected %0d %h %0d",
                                 $time, result_trans_id_i, result_data_i, result_exc_i,
                                 exp_tid, exp_data, exp_exc);
                    end
                end
            end
            if (valid_i && ready_i) begin
                exp_data = expect_result(op_i, operand_a_i, operand_b_i, imm_i, exp_exc);
                tid_q.push_back(trans_id_i);
                data_q.push_back(exp_data);
                exc_q.push_back(exp_exc);
                accepted_o++;
            end
        end
        pending_o = tid_q.size();
    end

endmodule

// ==== test/tb_lsu.sv ====
/*
 * Testbench top for the load/store unit. Runs a directed load, store and
 * misalignment sequence and then random requests, answers the four-phase
 * memory handshake from a 64-word array with random delays, and leaves
 * the comparing to the checker. A watchdog bounds the run.
 */
`timescale 1ns/100ps

module tb_lsu;

    localparam int          MEM_WORDS  = 64;
    localparam int          NUM_DIRECT = 12;
    localparam int          NUM_RANDOM = 300;
    localparam int          NUM_REQ    = NUM_DIRECT + NUM_RANDOM;
    localparam int          DRIVE_DLY  = 10;
    localparam logic [31:0] SEED       = 32'h9d2f;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             valid;
    lsu_pkg::lsu_op_e op;
    lsu_pkg::xlen_t   operand_a;
    lsu_pkg::xlen_t   operand_b;
    lsu_pkg::xlen_t   imm;
    lsu_pkg::tid_t    trans_id;
    logic             ready;
    logic             result_valid;
    lsu_pkg::tid_t    result_trans_id;
    lsu_pkg::xlen_t   result_data;
    lsu_pkg::exc_t    result_exc;
    logic             mem_req;
    logic             mem_we;
    lsu_pkg::waddr_t  mem_addr;
    lsu_pkg::be_t     mem_be;
    lsu_pkg::xlen_t   mem_wdata;
    logic             mem_ack;
    lsu_pkg::xlen_t   mem_rdata;
    lsu_pkg::xlen_t   mem [MEM_WORDS];
    int               accepted;
    int               pending;
    int               mismatches;
    int               extras;

    always #50 clk = ~clk;

    lsu_top DUT (
        .clk_i (clk), .rst_ni (rst_n),
        .valid_i (valid), .op_i (op), .operand_a_i (operand_a), .operand_b_i (operand_b),
        .imm_i (imm), .trans_id_i (trans_id), .ready_o (ready),
        .result_valid_o (result_valid), .result_trans_id_o (result_trans_id),
        .result_data_o (result_data), .result_exc_o (result_exc),
        .mem_req_o (mem_req), .mem_we_o (mem_we), .mem_addr_o (mem_addr),
        .mem_be_o (mem_be), .mem_wdata_o (mem_wdata),
        .mem_ack_i (mem_ack), .mem_rdata_i (mem_rdata)
    );

    lsu_checker i_checker (
        .clk_i (clk), .rst_ni (rst_n), .valid_i (valid), .ready_i (ready), .op_i (op),
        .operand_a_i (operand_a), .operand_b_i (operand_b), .imm_i (imm),
        .trans_id_i (trans_id), .mem_req_i (mem_req),
        .result_valid_i (result_valid), .result_trans_id_i (result_trans_id),
        .result_data_i (result_data), .result_exc_i (result_exc),
        .accepted_o (accepted), .pending_o (pending),
        .mismatch_o (mismatches), .extra_o (extras)
    );

    // same pattern as the shadow memory, each byte from its own address
    function automatic lsu_pkg::xlen_t fill_word(input int idx);
        logic [7:0] b;
        b = 8'(idx * 4);
        return {4{b}} ^ 32'hc35a_96e1;
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // one-cycle valid, only while ready is high
    task automatic send_request(input lsu_pkg::lsu_op_e o, input lsu_pkg::xlen_t a,
                                input lsu_pkg::xlen_t b, input lsu_pkg::xlen_t im);
        while (!ready) begin
            next_drive_slot();
        end
        valid     = 1'b1;
        op        = o;
        operand_a = a;
        operand_b = b;
        imm       = im;
        next_drive_slot();
        valid     = 1'b0;
        trans_id  = trans_id + 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // memory responder, four-phase with 0 to 3 cycles on each edge
    // ------------------------------------------------------------------------
    initial begin : mem_responder
        int idx;

        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            next_drive_slot();
            if (mem_req) begin
                repeat ($urandom_range(0, 3)) next_drive_slot();
                idx = int'(mem_addr[5:0]);
                if (mem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_be[b]) begin
                            mem[idx][8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    mem_rdata = mem[idx];
                end
                mem_ack = 1'b1;
                while (mem_req) begin
                    next_drive_slot();
                end
                repeat ($urandom_range(0, 3)) next_drive_slot();
                mem_ack = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        logic [31:0] r;

        void'($urandom(SEED));
        rst_n     = 1'b0;
        valid     = 1'b0;
        op        = lsu_pkg::LB;
        operand_a = '0;
        operand_b = '0;
        imm       = '0;
        trans_id  = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // every load kind on word 5
        send_request(lsu_pkg::LW,  32'h14, '0, 32'h0);
        send_request(lsu_pkg::LB,  32'h10, '0, 32'h7);
        send_request(lsu_pkg::LBU, 32'h18, '0, 32'hffff_fffd);
        send_request(lsu_pkg::LH,  32'h16, '0, 32'h0);
        send_request(lsu_pkg::LHU, 32'h14, '0, 32'h0);
        // partial stores into word 6, then read back
        send_request(lsu_pkg::SB,  32'h18, 32'h0000_00a5, 32'h1);
        send_request(lsu_pkg::SH,  32'h18, 32'h0000_7e3c, 32'h2);
        send_request(lsu_pkg::LW,  32'h18, '0, 32'h0);
        // misaligned, word 6 must not change
        send_request(lsu_pkg::SW,  32'h18, 32'hdead_beef, 32'h2);
        send_request(lsu_pkg::SH,  32'h19, 32'h0000_1234, 32'h0);
        send_request(lsu_pkg::LH,  32'h1b, '0, 32'h0);
        send_request(lsu_pkg::LW,  32'h18, '0, 32'h0);

        // random mix over a few words so stores and loads collide
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $urandom;
            send_request(lsu_pkg::lsu_op_e'(r[2:0]), {27'd0, r[8:4]} + 32'd4, $urandom,
                         {{28{r[12]}}, r[12:9]});
        end

        while (pending != 0) begin
            next_drive_slot();
        end
        repeat (4) next_drive_slot();
        $display("errors: %0d mismatches, %0d missing, %0d extra, %0d of %0d accepted",
                 mismatches, pending, extras, accepted, NUM_REQ);
        if (mismatches == 0 && pending == 0 && extras == 0 && accepted == NUM_REQ) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_REQ * 20 + 100) @(posedge clk);
        $display("watchdog: run did not finish, %0d of %0d requests accepted",
                 accepted, NUM_REQ);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
